// File: hw/cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef logic [15:0] instrWord; // Instruction register contents
    typedef logic [3:0]  flagBits; // Flag register value
    typedef logic [1:0]  memAddrSel; // Memory address source
    typedef logic [3:0]  aluFuncCode; // ALU operation
    typedef logic [3:0]  aluASel; // ALU input A source
    typedef logic [3:0]  aluBSel; // ALU input B source
    typedef logic [2:0]  destCode; // Destination or source field

    // Memory address sources
    localparam memAddrSel memFromPc = 2'd0;
    localparam memAddrSel memFromA  = 2'd1;

    // ALU input A, codes 0 to 3 pick the register file entry
    localparam aluASel aluAFromPc  = 4'd4;
    localparam aluASel aluAFromSp  = 4'd5;
    localparam aluASel aluAFromMem = 4'd6; // Value register

    // ALU input B, codes 0 to 3 pick the register file entry
    localparam aluBSel aluBFromOne  = 4'd4;
    localparam aluBSel aluBFromZero = 4'd5;
    localparam aluBSel aluBFromOp   = 4'd6; // Operand field of the instruction
    localparam aluBSel aluBFromAddr = 4'd7; // Jump offset field

    // Destination field codes
    localparam destCode destZero = 3'd0; // SP for I-type, no write otherwise
    localparam destCode destA    = 3'd1;
    localparam destCode destB    = 3'd2;
    localparam destCode destC    = 3'd3;
    localparam destCode destAdr  = 3'd4; // Memory at address A

    // Operand read modes held in s1
    localparam destCode srcCodeImmed = 3'd4;
    localparam destCode srcCodeAddr  = 3'd6;

    // ALU operations
    localparam aluFuncCode aluAdd  = 4'd0;
    localparam aluFuncCode aluSub  = 4'd2;
    localparam aluFuncCode aluJump = 4'd6;

    typedef enum logic [2:0] {
        classA,
        classI,
        classSI,
        classJump,
        classFlagJump,
        classFlagOp,
        classSkip, // Flag jump with false condition
        classInvalid
    } instrClass;

    typedef enum logic [1:0] {
        srcReg,
        srcImmed,
        srcAddr
    } srcMode;

    typedef enum logic [3:0] {
        START, FETCH, READIMMED, READADDR, EXECA, EXECI, EXECSI,
        EXECJUMP, EXECFLAGJUMP, HALT
    } ctrlState;

endpackage

// File: hw/decodeIf.sv
interface decodeIf;

    cpuCtrlPkg::instrClass  cls; // Instruction class
    cpuCtrlPkg::srcMode     mode; // Operand read mode
    cpuCtrlPkg::destCode    dest; // Result destination
    cpuCtrlPkg::aluASel     regA; // Register-mode ALU A source
    cpuCtrlPkg::aluBSel     regB;
    cpuCtrlPkg::aluFuncCode func;
    cpuCtrlPkg::flagBits    newFlags; // Flags after set or clear

    modport decoder (
        output cls, mode, dest, regA, regB, func, newFlags
    );

    modport sequencer (
        input cls, mode, dest
    );

    modport wordGen (
        input cls, mode, dest, regA, regB, func, newFlags
    );

endinterface

// File: hw/opcodeDecoder.sv
module opcodeDecoder (
    input  cpuCtrlPkg::instrWord opcode,
    input  cpuCtrlPkg::flagBits  flags,
    decodeIf.decoder             dec
);

    cpuCtrlPkg::destCode    s1; // Source 1 field, shared by all types
    cpuCtrlPkg::srcMode     s1Mode;
    logic                   modeValid;
    cpuCtrlPkg::instrClass  baseCls;
    cpuCtrlPkg::destCode    destSel;
    cpuCtrlPkg::aluASel     aSel;
    cpuCtrlPkg::aluBSel     bSel;
    cpuCtrlPkg::aluFuncCode funcSel;
    cpuCtrlPkg::flagBits    flagMask;
    logic                   usesOperand; // A, I and SI read through s1

    assign s1 = opcode[11:9];
    assign flagMask = cpuCtrlPkg::flagBits'(4'b0001 << opcode[9:8]);

    // Read mode from s1
    always_comb begin
        modeValid = 1'b1;
        case (s1)
            cpuCtrlPkg::srcCodeImmed: s1Mode = cpuCtrlPkg::srcImmed;
            cpuCtrlPkg::srcCodeAddr:  s1Mode = cpuCtrlPkg::srcAddr;
            default: begin
                s1Mode = cpuCtrlPkg::srcReg;
                modeValid = ~s1[2]; // 5 and 7 not supported
            end
        endcase
    end

    // Class and the fields that go with it
    always_comb begin
        baseCls = cpuCtrlPkg::classInvalid;
        destSel = opcode[2:0];
        funcSel = opcode[8:5];
        bSel = cpuCtrlPkg::aluBFromOp;
        aSel = {2'b00, s1[1:0]};
        if (opcode[15:12] == 4'b0000) begin // A-type
            baseCls = cpuCtrlPkg::classA;
            bSel = {2'b00, opcode[4:3]};
        end else if (opcode[15:14] == 2'b01) begin // I-type
            baseCls = cpuCtrlPkg::classI;
            destSel = s1;
            funcSel = {opcode[8], opcode[8], opcode[13:12]};
            if (s1 == cpuCtrlPkg::destZero) begin
                aSel = cpuCtrlPkg::aluAFromSp; // s1 of zero names SP here
            end
        end else if (opcode[15]) begin // J-type
            baseCls = cpuCtrlPkg::classJump;
        end else if (opcode[15:12] == 4'b0001) begin // SI-type
            baseCls = cpuCtrlPkg::classSI;
            destSel = opcode[6:4];
            funcSel = {2'b10, opcode[8:7]};
        end else if (opcode[15:12] == 4'b0010) begin // F-type
            if (opcode[11]) begin
                baseCls = cpuCtrlPkg::classFlagOp;
            end else if (flags[opcode[9:8]] == opcode[10]) begin
                baseCls = cpuCtrlPkg::classFlagJump;
            end else begin
                baseCls = cpuCtrlPkg::classSkip;
            end
        end
    end

    assign usesOperand = (baseCls == cpuCtrlPkg::classA)
                      || (baseCls == cpuCtrlPkg::classI)
                      || (baseCls == cpuCtrlPkg::classSI);

    // Unsupported mode or destination stops the CPU
    always_comb begin
        dec.cls = baseCls;
        if (usesOperand && (!modeValid || destSel > cpuCtrlPkg::destAdr)) begin
            dec.cls = cpuCtrlPkg::classInvalid;
        end
    end

    assign dec.mode = usesOperand ? s1Mode : cpuCtrlPkg::srcReg;
    assign dec.dest = destSel;
    assign dec.regA = aSel;
    assign dec.regB = bSel;
    assign dec.func = funcSel;
    assign dec.newFlags = opcode[10] ? (flags | flagMask) : (flags & ~flagMask);

endmodule

// File: hw/controlSequencer.sv
module controlSequencer (
    input  logic                 clk,
    input  logic                 rst,
    decodeIf.sequencer           dec,
    output cpuCtrlPkg::ctrlState state
);

    cpuCtrlPkg::ctrlState nextState;
    cpuCtrlPkg::ctrlState execState; // Execute state of current class
    cpuCtrlPkg::ctrlState fetchTarget; // Successor of FETCH

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpuCtrlPkg::START;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (dec.cls)
            cpuCtrlPkg::classA:        execState = cpuCtrlPkg::EXECA;
            cpuCtrlPkg::classI:        execState = cpuCtrlPkg::EXECI;
            cpuCtrlPkg::classSI:       execState = cpuCtrlPkg::EXECSI;
            cpuCtrlPkg::classJump:     execState = cpuCtrlPkg::EXECJUMP;
            cpuCtrlPkg::classFlagJump: execState = cpuCtrlPkg::EXECFLAGJUMP;
            default:                   execState = cpuCtrlPkg::HALT;
        endcase
    end

    always_comb begin
        case (dec.cls)
            cpuCtrlPkg::classFlagOp,
            cpuCtrlPkg::classSkip: begin
                fetchTarget = cpuCtrlPkg::FETCH; // Done in the fetch cycle
            end
            cpuCtrlPkg::classInvalid: begin
                fetchTarget = cpuCtrlPkg::HALT;
            end
            default: begin
                case (dec.mode)
                    cpuCtrlPkg::srcImmed: fetchTarget = cpuCtrlPkg::READIMMED;
                    cpuCtrlPkg::srcAddr:  fetchTarget = cpuCtrlPkg::READADDR;
                    default:              fetchTarget = execState;
                endcase
            end
        endcase
    end

    always_comb begin
        nextState = cpuCtrlPkg::HALT; // Unknown state stops the CPU
        case (state)
            cpuCtrlPkg::START: nextState = cpuCtrlPkg::FETCH;
            cpuCtrlPkg::FETCH: nextState = fetchTarget;
            cpuCtrlPkg::READIMMED,
            cpuCtrlPkg::READADDR: nextState = execState; // Operand now in value register
            cpuCtrlPkg::EXECA,
            cpuCtrlPkg::EXECI,
            cpuCtrlPkg::EXECSI,
            cpuCtrlPkg::EXECJUMP,
            cpuCtrlPkg::EXECFLAGJUMP: nextState = cpuCtrlPkg::FETCH;
            cpuCtrlPkg::HALT: nextState = cpuCtrlPkg::HALT; // Left only by rst
            default: nextState = cpuCtrlPkg::HALT;
        endcase
    end

endmodule

// File: hw/controlWordGen.sv
module controlWordGen (
    input  cpuCtrlPkg::ctrlState   state,
    decodeIf.wordGen               dec,
    output cpuCtrlPkg::memAddrSel  memAddr, // Memory address source
    output logic                   enPC,
    output logic                   saveOpcode, // Load instruction register
    output logic                   saveMem, // Load value register
    output cpuCtrlPkg::aluFuncCode aluFunc,
    output cpuCtrlPkg::aluASel     aluA,
    output cpuCtrlPkg::aluBSel     aluB,
    output logic                   enA,
    output logic                   enB,
    output logic                   enC,
    output logic                   we,
    output logic                   re,
    output logic                   enF, // Flag register write
    output logic                   sourceF, // Flags from inF, not the ALU
    output cpuCtrlPkg::flagBits    inF,
    output logic                   enSP,
    output logic                   initSP
);

    always_comb begin
        memAddr = cpuCtrlPkg::memFromPc; // Idle control word
        enPC = 1'b0;
        saveOpcode = 1'b0;
        saveMem = 1'b0;
        aluFunc = cpuCtrlPkg::aluAdd;
        aluA = '0;
        aluB = '0;
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        we = 1'b0;
        re = 1'b0;
        enF = 1'b0;
        sourceF = 1'b0;
        inF = '0;
        enSP = 1'b0;
        initSP = 1'b0;

        case (state)
            cpuCtrlPkg::START: begin
                enSP = 1'b1;
                initSP = 1'b1; // Load SP with its start value
            end

            cpuCtrlPkg::FETCH: begin
                memAddr = cpuCtrlPkg::memFromPc;
                re = 1'b1;
                saveOpcode = 1'b1;
                aluFunc = cpuCtrlPkg::aluAdd; // PC + 1
                aluA = cpuCtrlPkg::aluAFromPc;
                aluB = cpuCtrlPkg::aluBFromOne;
                enPC = 1'b1;
                if (dec.cls == cpuCtrlPkg::classFlagOp) begin
                    enF = 1'b1; // Flag set or clear completes here
                    sourceF = 1'b1;
                    inF = dec.newFlags;
                end
            end

            cpuCtrlPkg::READIMMED: begin
                memAddr = cpuCtrlPkg::memFromPc; // Operand follows the opcode
                re = 1'b1;
                saveMem = 1'b1;
                aluFunc = cpuCtrlPkg::aluAdd;
                aluA = cpuCtrlPkg::aluAFromPc;
                aluB = cpuCtrlPkg::aluBFromOne;
                enPC = 1'b1;
            end

            cpuCtrlPkg::READADDR: begin
                memAddr = cpuCtrlPkg::memFromA;
                re = 1'b1;
                saveMem = 1'b1;
            end

            cpuCtrlPkg::EXECA,
            cpuCtrlPkg::EXECI,
            cpuCtrlPkg::EXECSI: begin
                if (dec.mode == cpuCtrlPkg::srcReg) begin
                    aluA = dec.regA;
                end else begin
                    aluA = cpuCtrlPkg::aluAFromMem; // Operand read before
                end
                aluB = dec.regB;
                aluFunc = dec.func;
                enF = 1'b1;
                case (dec.dest)
                    cpuCtrlPkg::destZero: enSP = (state == cpuCtrlPkg::EXECI);
                    cpuCtrlPkg::destA: enA = 1'b1;
                    cpuCtrlPkg::destB: enB = 1'b1;
                    cpuCtrlPkg::destC: enC = 1'b1;
                    cpuCtrlPkg::destAdr: begin
                        we = 1'b1;
                        memAddr = cpuCtrlPkg::memFromA;
                    end
                    default: we = 1'b0;
                endcase
            end

            cpuCtrlPkg::EXECJUMP: begin
                aluFunc = cpuCtrlPkg::aluJump; // Relative jump
                aluA = cpuCtrlPkg::aluAFromPc;
                aluB = cpuCtrlPkg::aluBFromAddr;
                enPC = 1'b1;
            end

            cpuCtrlPkg::EXECFLAGJUMP: begin
                aluFunc = cpuCtrlPkg::aluAdd; // PC plus operand offset
                aluA = cpuCtrlPkg::aluAFromPc;
                aluB = cpuCtrlPkg::aluBFromOp;
                enPC = 1'b1;
            end

            default: begin
                // HALT keeps the idle word
            end
        endcase
    end

endmodule

// File: hw/cpuController.sv
module cpuController (
    input  logic                   clk,
    input  logic                   rst,
    input  cpuCtrlPkg::instrWord   opcode, // Current instruction
    input  cpuCtrlPkg::flagBits    flags, // Current flag register

    output cpuCtrlPkg::memAddrSel  memAddr,
    output logic                   enPC,
    output logic                   saveOpcode,
    output logic                   saveMem,
    output cpuCtrlPkg::aluFuncCode aluFunc,
    output cpuCtrlPkg::aluASel     aluA,
    output cpuCtrlPkg::aluBSel     aluB,
    output logic                   enA,
    output logic                   enB,
    output logic                   enC,
    output logic                   we,
    output logic                   re,
    output logic                   enF,
    output logic                   sourceF,
    output cpuCtrlPkg::flagBits    inF,
    output logic                   enSP,
    output logic                   initSP
);

    cpuCtrlPkg::ctrlState state; // Current FSM state

    decodeIf decBus ();

    opcodeDecoder decoder0 (
        .opcode (opcode),
        .flags  (flags),
        .dec    (decBus.decoder)
    );

    controlSequencer sequencer0 (
        .clk   (clk),
        .rst   (rst),
        .dec   (decBus.sequencer),
        .state (state)
    );

    controlWordGen wordGen0 (
        .state      (state),
        .dec        (decBus.wordGen),
        .memAddr    (memAddr),
        .enPC       (enPC),
        .saveOpcode (saveOpcode),
        .saveMem    (saveMem),
        .aluFunc    (aluFunc),
        .aluA       (aluA),
        .aluB       (aluB),
        .enA        (enA),
        .enB        (enB),
        .enC        (enC),
        .we         (we),
        .re         (re),
        .enF        (enF),
        .sourceF    (sourceF),
        .inF        (inF),
        .enSP       (enSP),
        .initSP     (initSP)
    );

endmodule

// File: sim/ctrlVectors.svh
// Columns: name, opcode, flags, cycles from fetch to next fetch, aluFunc, aluA, aluB,
// enables {enA, enB, enC, enSP, we, enF}, inF; zero cycles means the FSM halts
task automatic fillVectorTable();
    // A-type, register and address mode
    addVector("aTypeAdd",       16'h0419, 4'h0, 2, 4'd0,  4'd2, 4'd3, 6'b100001, 4'h0);
    addVector("aTypeSubToMem",  16'h0254, 4'h0, 2, 4'd2,  4'd1, 4'd2, 6'b000011, 4'h0);
    addVector("aTypeNoDest",    16'h06A8, 4'h0, 2, 4'd5,  4'd3, 4'd1, 6'b000001, 4'h0);
    addVector("aTypeAddrMode",  16'h0C0A, 4'h0, 3, 4'd0,  4'd6, 4'd1, 6'b010001, 4'h0);

    // SI-type, B input is the operand field
    addVector("siTypeReg",      16'h14B0, 4'h0, 2, 4'd9,  4'd2, 4'd6, 6'b001001, 4'h0);
    addVector("siTypeAddrMode", 16'h1D20, 4'h0, 3, 4'd10, 4'd6, 4'd6, 6'b010001, 4'h0);

    // I-type, s1 is source and destination
    addVector("iTypeImmed",     16'h6800, 4'h0, 3, 4'd2,  4'd6, 4'd6, 6'b000011, 4'h0);
    addVector("iTypeSp",        16'h5100, 4'h0, 2, 4'd13, 4'd5, 4'd6, 6'b000101, 4'h0);
    addVector("iTypeRegC",      16'h4600, 4'h0, 2, 4'd0,  4'd3, 4'd6, 6'b001001, 4'h0);

    // Jumps
    addVector("jumpRel",        16'h8005, 4'h0, 2, 4'd6,  4'd4, 4'd7, 6'b000000, 4'h0);
    addVector("flagJumpOnSet",  16'h2500, 4'h2, 2, 4'd0,  4'd4, 4'd6, 6'b000000, 4'h0);
    addVector("flagJumpOnClr",  16'h2300, 4'h0, 2, 4'd0,  4'd4, 4'd6, 6'b000000, 4'h0);
    addVector("flagJumpSkip",   16'h2200, 4'h4, 1, 4'd0,  4'd4, 4'd4, 6'b000000, 4'h0);

    // Flag set and clear finish in the fetch cycle
    addVector("flagSet",        16'h2E00, 4'h1, 1, 4'd0,  4'd4, 4'd4, 6'b000001, 4'h5);
    addVector("flagClear",      16'h2800, 4'hB, 1, 4'd0,  4'd4, 4'd4, 6'b000001, 4'hA);

    // Unsupported opcodes, each followed by a normal one after reset
    addVector("haltStackOp",    16'h3000, 4'h0, 0, 4'd0,  4'd0, 4'd0, 6'b000000, 4'h0);
    addVector("addAfterReset",  16'h0419, 4'h0, 2, 4'd0,  4'd2, 4'd3, 6'b100001, 4'h0);
    addVector("haltAbsMode",    16'h0A01, 4'h0, 0, 4'd0,  4'd0, 4'd0, 6'b000000, 4'h0);
    addVector("haltDest7",      16'h0207, 4'h0, 0, 4'd0,  4'd0, 4'd0, 6'b000000, 4'h0);
    addVector("iTypeAfterHalt", 16'h4600, 4'h0, 2, 4'd0,  4'd3, 4'd6, 6'b001001, 4'h0);
endtask

// File: sim/cpuControllerTb.sv
module cpuControllerTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int waitLimit = 20; // Cycles allowed for any wait
    localparam int haltCycles = 10;

    logic                   clk;
    logic                   rst;
    cpuCtrlPkg::instrWord   opcode;
    cpuCtrlPkg::flagBits    flags;
    cpuCtrlPkg::memAddrSel  memAddr;
    logic                   enPC;
    logic                   saveOpcode;
    logic                   saveMem;
    cpuCtrlPkg::aluFuncCode aluFunc;
    cpuCtrlPkg::aluASel     aluA;
    cpuCtrlPkg::aluBSel     aluB;
    logic                   enA;
    logic                   enB;
    logic                   enC;
    logic                   we;
    logic                   re;
    logic                   enF;
    logic                   sourceF;
    cpuCtrlPkg::flagBits    inF;
    logic                   enSP;
    logic                   initSP;

    string                  vecName[$];
    cpuCtrlPkg::instrWord   vecOpcode[$];
    cpuCtrlPkg::flagBits    vecFlags[$];
    int                     vecCycles[$]; // Zero when HALT is expected
    cpuCtrlPkg::aluFuncCode vecFunc[$];
    cpuCtrlPkg::aluASel     vecAluA[$];
    cpuCtrlPkg::aluBSel     vecAluB[$];
    logic [5:0]             vecEn[$]; // {enA, enB, enC, enSP, we, enF}
    cpuCtrlPkg::flagBits    vecInF[$];

    cpuController dut0 (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .flags      (flags),
        .memAddr    (memAddr),
        .enPC       (enPC),
        .saveOpcode (saveOpcode),
        .saveMem    (saveMem),
        .aluFunc    (aluFunc),
        .aluA       (aluA),
        .aluB       (aluB),
        .enA        (enA),
        .enB        (enB),
        .enC        (enC),
        .we         (we),
        .re         (re),
        .enF        (enF),
        .sourceF    (sourceF),
        .inF        (inF),
        .enSP       (enSP),
        .initSP     (initSP)
    );

    always #4 clk = ~clk; // 8 ns period

    `include "ctrlVectors.svh"

    task automatic addVector(input string name, input cpuCtrlPkg::instrWord op,
                             input cpuCtrlPkg::flagBits fl, input int cycles,
                             input cpuCtrlPkg::aluFuncCode func, input cpuCtrlPkg::aluASel a,
                             input cpuCtrlPkg::aluBSel b, input logic [5:0] en,
                             input cpuCtrlPkg::flagBits newF);
        vecName.push_back(name);
        vecOpcode.push_back(op);
        vecFlags.push_back(fl);
        vecCycles.push_back(cycles);
        vecFunc.push_back(func);
        vecAluA.push_back(a);
        vecAluB.push_back(b);
        vecEn.push_back(en);
        vecInF.push_back(newF);
    endtask

    // All control outputs, initSP in bit 0
    function automatic logic [31:0] outputsWord();
        return {2'b00, memAddr, enPC, saveOpcode, saveMem, aluFunc, aluA, aluB,
                enA, enB, enC, we, re, enF, sourceF, inF, enSP, initSP};
    endfunction

    task automatic checkVal(input string testName, input string sigName,
                            input logic [31:0] expVal, input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("ERROR %s %s expected 0x%0h actual 0x%0h",
                     testName, sigName, expVal, actVal);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timeout: %s", what);
        $display("Something failed");
        $fatal(1, "wait expired");
    endtask

    task automatic waitFetch(input string testName);
        int waited;
        waited = 0;
        while (saveOpcode !== 1'b1) begin
            if (waited >= waitLimit) begin
                failTimeout($sformatf("%s: no fetch cycle within %0d cycles",
                                      testName, waitLimit));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Two reset cycles, then START and the first FETCH
    task automatic runReset(input string testName);
        rst = 1'b1;
        opcode = '0; // A-type without destination
        flags = '0;
        repeat (2) begin
            @(negedge clk);
            checkVal(testName, "outputs in reset", 32'h3, outputsWord());
        end
        rst = 1'b0;
        #2;
        checkVal(testName, "outputs in START", 32'h3, outputsWord());
        @(negedge clk);
        checkVal(testName, "saveOpcode after START", 1, saveOpcode);
        checkVal(testName, "re after START", 1, re);
        checkVal(testName, "enPC after START", 1, enPC);
    endtask

    task automatic runVector(input int idx);
        string testName;
        int cycles;
        bit found;
        logic [31:0] lastWord; // Cycle before the next fetch
        logic [31:0] readWord; // Second cycle, the operand read
        logic [5:0] lastEn;
        testName = vecName[idx];
        opcode = vecOpcode[idx];
        flags = vecFlags[idx];
        #2; // Decode settles inside the fetch cycle
        checkVal(testName, "re in FETCH", 1, re);
        checkVal(testName, "saveOpcode in FETCH", 1, saveOpcode);
        checkVal(testName, "enPC in FETCH", 1, enPC);
        if (vecCycles[idx] == 0) begin
            repeat (haltCycles) begin
                @(negedge clk);
                checkVal(testName, "outputs in HALT", 0, outputsWord());
            end
            runReset(testName);
        end else begin
            lastWord = outputsWord();
            readWord = '0;
            cycles = 1;
            found = 1'b0;
            while (!found) begin
                if (cycles >= waitLimit) begin
                    failTimeout($sformatf("%s: next fetch not seen within %0d cycles",
                                          testName, waitLimit));
                end
                @(negedge clk);
                if (saveOpcode === 1'b1) begin
                    found = 1'b1;
                end else begin
                    cycles++;
                    lastWord = outputsWord();
                    if (cycles == 2) begin
                        readWord = lastWord;
                    end
                end
            end
            checkVal(testName, "cycle count", vecCycles[idx], cycles);
            lastEn = {lastWord[12], lastWord[11], lastWord[10], lastWord[1], lastWord[9],
                      lastWord[7]};
            checkVal(testName, "aluFunc", vecFunc[idx], lastWord[24:21]);
            checkVal(testName, "aluA", vecAluA[idx], lastWord[20:17]);
            checkVal(testName, "aluB", vecAluB[idx], lastWord[16:13]);
            checkVal(testName, "enables", vecEn[idx], lastEn);
            checkVal(testName, "inF", vecInF[idx], lastWord[5:2]);
            checkVal(testName, "memAddr", vecEn[idx][1] ? cpuCtrlPkg::memFromA
                                                       : cpuCtrlPkg::memFromPc,
                     lastWord[29:28]);
            checkVal(testName, "enPC", vecAluA[idx] == cpuCtrlPkg::aluAFromPc, lastWord[27]);
            checkVal(testName, "sourceF", (cycles == 1) && vecEn[idx][0], lastWord[6]);
            if (vecCycles[idx] == 3) begin
                checkVal(testName, "re in read", 1, readWord[8]);
                checkVal(testName, "saveMem in read", 1, readWord[25]);
                // Only the immediate read steps past the operand
                checkVal(testName, "enPC in read",
                         vecOpcode[idx][11:9] == cpuCtrlPkg::srcCodeImmed, readWord[27]);
            end
        end
    endtask

    initial begin
        int idx;
        clk = 1'b0;
        rst = 1'b1;
        opcode = '0;
        flags = '0;
        fillVectorTable();
        runReset("startup");
        for (idx = 0; idx < vecName.size(); idx++) begin
            waitFetch(vecName[idx]);
            runVector(idx);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: flist.f
+incdir+sim
hw/cpuCtrlPkg.sv
hw/decodeIf.sv
hw/opcodeDecoder.sv
hw/controlSequencer.sv
hw/controlWordGen.sv
hw/cpuController.sv
sim/cpuControllerTb.sv
